/* sched_state_pkg.sv */
`default_nettype none

// state and mode encodings shared by the schedule controller
package sched_state_pkg;

	// ----------------------------------------------------------------------
	// master mode, driven by the top-level master FSM
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		MAST_IDLE  = 3'd0,
		MAST_LEFT  = 3'd1,	// left edge block, padded
		MAST_BASE  = 3'd2,	// inner block, no padding
		MAST_RIGHT = 3'd3,	// right edge block, padded
		MAST_FSLD  = 3'd7	// first load of kernel/bias/pad
	} mast_state_e;

	// first-load phase
	typedef enum logic [2:0] {
		FS_IDLE = 3'd0,
		FS_KER  = 3'd1,
		FS_BIAS = 3'd2,
		FS_IFPD = 3'd3,
		FS_DONE = 3'd7		// single cycle, raises fsld_end
	} fsld_state_e;

	// per-block phase
	typedef enum logic [1:0] {
		BK_IDLE = 2'd0,
		BK_PADD = 2'd1,
		BK_FSLD = 2'd2,		// first three-row feature load
		BK_RDWT = 2'd3		// row read/write loop
	} block_state_e;

	// row read phase inside BK_RDWT
	typedef enum logic [2:0] {
		ROW_IDLE     = 3'd0,
		ROW_UP_PAD   = 3'd1,
		ROW_THREE    = 3'd2,	// read 3 rows from top bank, load next 3
		ROW_TWO      = 3'd3,
		ROW_ONE      = 3'd4,
		ROW_DOWN_PAD = 3'd5
	} row_state_e;

	localparam int unsigned ROWS_PER_LOAD = 3;	// rows per feature load

endpackage

`default_nettype wire

/* sched_bus_pkg.sv */
`default_nettype none

// grouped handshake and bank select signals
package sched_bus_pkg;

	// status of one loader unit
	typedef struct packed {
		logic busy;	// level, unit running
		logic done;	// one-cycle pulse at end of busy
	} unit_status_t;

	// start levels to the kernel, bias and padding units
	typedef struct packed {
		logic ker;
		logic bias;
		logic pad;
	} load_starts_t;

	// ping-pong feature bank select, at most one bit high
	typedef struct packed {
		logic bank1;
		logic bank0;
	} bank_sel_t;

endpackage

`default_nettype wire

/* sched_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module sched_ctrl
	import sched_state_pkg::*;
	import sched_bus_pkg::*;
#(
	parameter int ROW_W = 8
) (
	input  wire logic         clk,
	input  wire logic         reset,
	input  wire mast_state_e  mast_state,
	input  wire unit_status_t ker_status,
	input  wire unit_status_t bias_status,
	input  wire unit_status_t pad_status,
	input  wire unit_status_t wr_status,
	input  wire logic         rdwd_done,	// pulse from row loop
	output fsld_state_e       fsld_state,
	output block_state_e      block_state,
	output logic              fsld_end,
	output logic              left_done,
	output logic              base_done,
	output logic              right_done
);

	fsld_state_e  fsld_next;
	block_state_e block_next;
	logic         mode_lr;	// padded block modes
	logic         mode_bs;

	// row counter has to hold at least one load step
	if (ROW_W < $clog2(ROWS_PER_LOAD + 1)) begin : g_row_w_check
		$error("ROW_W too narrow for one row step");
	end

	assign mode_lr = (mast_state == MAST_LEFT) || (mast_state == MAST_RIGHT);
	assign mode_bs = (mast_state == MAST_BASE);

	// ----------------------------------------------------------------------
	// first load FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			fsld_state <= FS_IDLE;
		end else begin
			fsld_state <= fsld_next;
		end
	end

	always_comb begin
		fsld_next = fsld_state;	// hold by default
		case (fsld_state)
			FS_IDLE: if (mast_state == MAST_FSLD) fsld_next = FS_KER;
			FS_KER:  if (ker_status.done)  fsld_next = FS_BIAS;
			FS_BIAS: if (bias_status.done) fsld_next = FS_IFPD;
			FS_IFPD: if (pad_status.done)  fsld_next = FS_DONE;
			FS_DONE: fsld_next = FS_IDLE;	// one cycle only
			default: fsld_next = FS_IDLE;
		endcase
	end

	// end flag back to master FSM
	assign fsld_end = (mast_state == MAST_FSLD) && (fsld_state == FS_DONE);

	// ----------------------------------------------------------------------
	// block FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			block_state <= BK_IDLE;
		end else begin
			block_state <= block_next;
		end
	end

	always_comb begin
		block_next = block_state;
		case (block_state)
			BK_IDLE: begin
				if (mode_lr) begin
					block_next = BK_PADD;	// edge blocks pad first
				end else if (mode_bs) begin
					block_next = BK_FSLD;
				end
			end
			BK_PADD: if (pad_status.done) block_next = BK_FSLD;
			BK_FSLD: if (wr_status.done)  block_next = BK_RDWT;	// first 3 rows in
			BK_RDWT: if (rdwd_done)       block_next = BK_IDLE;
			default: block_next = BK_IDLE;
		endcase
	end

	// steer block end to the active mode
	assign left_done  = rdwd_done && (mast_state == MAST_LEFT);
	assign base_done  = rdwd_done && (mast_state == MAST_BASE);
	assign right_done = rdwd_done && (mast_state == MAST_RIGHT);

	// block end can only come out of the row loop
	a_done_in_rdwt: assert property (@(posedge clk) disable iff (reset)
		rdwd_done |-> (block_state == BK_RDWT))
		else $error("rdwd_done outside BK_RDWT");

	a_one_block_done: assert property (@(posedge clk) disable iff (reset)
		$onehot0({left_done, base_done, right_done}))
		else $error("more than one block done output high");

endmodule

`default_nettype wire

/* load_start_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module load_start_gen
	import sched_state_pkg::*;
	import sched_bus_pkg::*;
(
	input  wire logic         clk,
	input  wire logic         reset,
	input  wire fsld_state_e  fsld_state,
	input  wire block_state_e block_state,
	input  wire unit_status_t ker_status,
	input  wire unit_status_t bias_status,
	input  wire unit_status_t pad_status,
	output load_starts_t      load_starts
);

	logic ker_want;
	logic bias_want;
	logic pad_want;

	// start only while the unit is free and not just finishing
	function automatic logic start_ok(input logic want, input unit_status_t st);
		return want & ~st.busy & ~st.done;
	endfunction

	assign ker_want  = (fsld_state == FS_KER);
	assign bias_want = (fsld_state == FS_BIAS);
	// padding shared by first load and edge blocks
	assign pad_want  = (fsld_state == FS_IFPD) || (block_state == BK_PADD);

	// ----------------------------------------------------------------------
	// registered starts, one cycle behind the phase
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			load_starts <= '0;
		end else begin
			load_starts.ker  <= start_ok(ker_want, ker_status);
			load_starts.bias <= start_ok(bias_want, bias_status);
			load_starts.pad  <= start_ok(pad_want, pad_status);
		end
	end

	// phases of both FSMs never overlap on the loaders
	a_one_start: assert property (@(posedge clk) disable iff (reset)
		$onehot0(load_starts))
		else $error("two load starts high together");

endmodule

`default_nettype wire

/* if_write_sched.sv */
`timescale 1ns/100ps
`default_nettype none

module if_write_sched
	import sched_state_pkg::*;
	import sched_bus_pkg::*;
#(
	parameter int ROW_W = 8
) (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic [ROW_W-1:0] cfg_total_row,	// nonzero, multiple of 3
	input  wire block_state_e     block_state,
	input  wire row_state_e       row_state,
	input  wire unit_status_t     wr_status,
	input  wire logic             rd_done,
	output logic                  if_write_start,
	output bank_sel_t             wr_bank,
	output logic                  read_last,
	output logic                  load_more
);

	localparam logic [ROW_W-1:0] ROW_STEP = ROW_W'(ROWS_PER_LOAD);

	logic [ROW_W-1:0] row_cnt;	// rows loaded in this block
	logic [ROW_W-1:0] load_idx;
	logic             pass_wr;	// write done in current three-row pass
	logic             wr_want;

	// ----------------------------------------------------------------------
	// row counter
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || block_state == BK_IDLE) begin
			row_cnt <= '0;
		end else if (wr_status.done &&
			(block_state == BK_FSLD || row_state == ROW_THREE)) begin
			row_cnt <= row_cnt + ROW_STEP;
		end
	end

	assign read_last = (row_cnt == cfg_total_row);

	// pass closes when the one-row read hands over to the next three-row
	always_ff @(posedge clk) begin
		if (reset || block_state == BK_IDLE) begin
			pass_wr <= 1'b0;
		end else if (row_state == ROW_ONE && rd_done) begin
			pass_wr <= 1'b0;
		end else if (row_state == ROW_THREE && wr_status.done) begin
			pass_wr <= 1'b1;
		end
	end

	assign load_more = (row_state == ROW_THREE) && (row_cnt < cfg_total_row) && !pass_wr;
	assign wr_want   = (block_state == BK_FSLD) || load_more;

	always_ff @(posedge clk) begin
		if (reset) begin
			if_write_start <= 1'b0;
		end else begin
			if_write_start <= wr_want & ~wr_status.busy & ~wr_status.done;
		end
	end

	// ----------------------------------------------------------------------
	// write bank, even load index -> bank 0
	// ----------------------------------------------------------------------
	assign load_idx = row_cnt / ROW_STEP;

	always_ff @(posedge clk) begin
		if (reset || wr_status.done) begin
			wr_bank <= '0;
		end else if (if_write_start) begin
			wr_bank.bank0 <= ~load_idx[0];
			wr_bank.bank1 <= load_idx[0];
		end
	end

	a_wr_bank_excl: assert property (@(posedge clk) disable iff (reset)
		!(wr_bank.bank0 && wr_bank.bank1))
		else $error("both write banks selected");

	// loads stop at the configured total
	a_cnt_bound: assert property (@(posedge clk) disable iff (reset)
		(block_state != BK_IDLE) |-> (row_cnt <= cfg_total_row))
		else $error("row counter past cfg_total_row");

endmodule

`default_nettype wire

/* if_read_sched.sv */
`timescale 1ns/100ps
`default_nettype none

module if_read_sched
	import sched_state_pkg::*;
	import sched_bus_pkg::*;
(
	input  wire logic         clk,
	input  wire logic         reset,
	input  wire block_state_e block_state,
	input  wire unit_status_t rd_status,
	input  wire logic         wr_done,
	input  wire logic         read_last,
	input  wire logic         load_more,
	input  wire bank_sel_t    wr_bank,
	output row_state_e        row_state,
	output logic              if_read_start,
	output bank_sel_t         rd_bank,
	output logic              rdwd_done
);

	row_state_e row_next;
	logic       rd_seen;	// three-row read finished, waiting on write
	logic       wr_seen;	// three-row write finished, waiting on read
	logic       join_rd;
	logic       join_wr;
	logic       top_bank;	// 0: bank 0 holds top rows
	logic       use_other;
	logic       rd_want;

	assign join_rd = rd_seen | rd_status.done;
	assign join_wr = wr_seen | wr_done;

	// ----------------------------------------------------------------------
	// row FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			row_state <= ROW_IDLE;
		end else begin
			row_state <= row_next;
		end
	end

	always_comb begin
		row_next = row_state;
		case (row_state)
			ROW_IDLE: begin
				// rdwd_done still up while block leaves rdwt
				if (block_state == BK_RDWT && !rdwd_done) row_next = ROW_UP_PAD;
			end
			ROW_UP_PAD: if (rd_status.done) row_next = ROW_THREE;
			ROW_THREE: begin
				if (load_more || wr_seen) begin
					if (join_rd && join_wr) row_next = ROW_TWO;	// read and load both in
				end else if (read_last && rd_status.done) begin
					row_next = ROW_DOWN_PAD;	// no rows left to load
				end
			end
			ROW_TWO:      if (rd_status.done) row_next = ROW_ONE;
			ROW_ONE:      if (rd_status.done) row_next = ROW_THREE;
			ROW_DOWN_PAD: if (rd_status.done) row_next = ROW_IDLE;
			default:      row_next = ROW_IDLE;
		endcase
	end

	// join flags live only inside one three-row visit
	always_ff @(posedge clk) begin
		if (reset || row_state != ROW_THREE || row_next != ROW_THREE) begin
			rd_seen <= 1'b0;
			wr_seen <= 1'b0;
		end else begin
			rd_seen <= join_rd;
			wr_seen <= join_wr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rdwd_done <= 1'b0;
		end else begin
			rdwd_done <= (row_state == ROW_DOWN_PAD) && rd_status.done;	// single pulse
		end
	end

	// one read per row state
	assign rd_want = (row_state != ROW_IDLE) && !rd_seen;

	always_ff @(posedge clk) begin
		if (reset) begin
			if_read_start <= 1'b0;
		end else begin
			if_read_start <= rd_want & ~rd_status.busy & ~rd_status.done;
		end
	end

	// ----------------------------------------------------------------------
	// top bank tracking and read select
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			top_bank <= 1'b0;
		end else if (block_state == BK_FSLD && wr_done) begin
			top_bank <= wr_bank.bank1;	// first load bank
		end else if (row_state == ROW_THREE && row_next == ROW_TWO) begin
			top_bank <= ~top_bank;	// fresh rows become top once the pass joins
		end
	end

	assign use_other = (row_state == ROW_TWO) || (row_state == ROW_ONE);

	always_comb begin
		rd_bank = '0;
		if (rd_status.busy && row_state != ROW_IDLE) begin
			rd_bank.bank1 = top_bank ^ use_other;
			rd_bank.bank0 = ~(top_bank ^ use_other);
		end
	end

	a_rd_bank_busy: assert property (@(posedge clk) disable iff (reset)
		(rd_bank != '0) |-> (rd_status.busy && $onehot(rd_bank)))
		else $error("read bank selected while read idle");

	// overlapped load never lands in the bank being read
	a_no_bank_clash: assert property (@(posedge clk) disable iff (reset)
		(row_state == ROW_THREE && rd_bank != '0 && wr_bank != '0) |-> (rd_bank != wr_bank))
		else $error("read and write on the same bank");

endmodule

`default_nettype wire

/* if_sched_top.sv */
`timescale 1ns/100ps
`default_nettype none

module if_sched_top
	import sched_state_pkg::*;
	import sched_bus_pkg::*;
#(
	parameter int ROW_W = 8
) (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire mast_state_e      mast_state,
	input  wire logic [ROW_W-1:0] cfg_total_row,
	input  wire unit_status_t     ker_status,
	input  wire unit_status_t     bias_status,
	input  wire unit_status_t     pad_status,
	input  wire unit_status_t     wr_status,
	input  wire unit_status_t     rd_status,
	output load_starts_t          load_starts,
	output logic                  if_write_start,
	output logic                  if_read_start,
	output bank_sel_t             wr_bank,
	output bank_sel_t             rd_bank,
	output logic                  fsld_end,
	output logic                  left_done,
	output logic                  base_done,
	output logic                  right_done
);

	fsld_state_e  fsld_state;
	block_state_e block_state;
	row_state_e   row_state;
	logic         read_last;	// write -> read
	logic         load_more;
	logic         rdwd_done;	// read -> ctrl

	// ----------------------------------------------------------------------
	// control and datapath schedulers
	// ----------------------------------------------------------------------
	sched_ctrl #(.ROW_W(ROW_W)) i_ctrl (
		.clk, .reset, .mast_state,
		.ker_status, .bias_status, .pad_status, .wr_status,
		.rdwd_done, .fsld_state, .block_state,
		.fsld_end, .left_done, .base_done, .right_done
	);

	load_start_gen i_start_gen (
		.clk, .reset, .fsld_state, .block_state,
		.ker_status, .bias_status, .pad_status, .load_starts
	);

	if_write_sched #(.ROW_W(ROW_W)) i_write (
		.clk, .reset, .cfg_total_row, .block_state, .row_state, .wr_status,
		.rd_done(rd_status.done), .if_write_start, .wr_bank, .read_last, .load_more
	);

	if_read_sched i_read (
		.clk, .reset, .block_state, .rd_status, .wr_done(wr_status.done),
		.read_last, .load_more, .wr_bank, .row_state,
		.if_read_start, .rd_bank, .rdwd_done
	);

endmodule

`default_nettype wire

/* tb_unit_model.sv */
`timescale 1ns/100ps
`default_nettype none

// loader unit stand-in, busy for a pseudo-random length then one done pulse
module tb_unit_model
	import sched_bus_pkg::*;
#(
	parameter int unsigned SEED    = 29,
	parameter int unsigned MAX_LEN = 6	// longest busy period, cycles
) (
	input  wire logic    clk,
	input  wire logic    reset,
	input  wire logic    start,
	output unit_status_t status
);

	unit_status_t status_q  = '0;
	logic [31:0]  lcg_state = SEED;
	int unsigned  remain    = 0;	// busy cycles left

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	assign status = status_q;

	// status changes on the falling edge, DUT samples on the rising one
	always @(negedge clk) begin
		if (reset) begin
			status_q  <= '0;
			remain    <= 0;
			lcg_state <= SEED;
		end else begin
			status_q.done <= 1'b0;	// single-cycle pulse
			if (status_q.busy) begin
				if (remain <= 1) begin
					status_q.busy <= 1'b0;	// done follows busy
					status_q.done <= 1'b1;
				end else begin
					remain <= remain - 1;
				end
			end else if (start && !status_q.done) begin
				lcg_state     <= lcg_next(lcg_state);
				remain        <= (lcg_next(lcg_state) >> 16) % MAX_LEN + 1;
				status_q.busy <= 1'b1;	// start ignored from here on
			end
		end
	end

endmodule

`default_nettype wire

/* tb_if_sched.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_if_sched
	import sched_state_pkg::*;
	import sched_bus_pkg::*;
();

	localparam int ROW_W      = 8;
	localparam int WAIT_LIMIT = 4000;	// cycles per wait

	logic             clk = 1'b0;
	logic             reset;
	mast_state_e      mast_state;
	logic [ROW_W-1:0] cfg_total_row;
	unit_status_t     ker_status, bias_status, pad_status, wr_status, rd_status;
	load_starts_t     load_starts;
	logic             if_write_start;
	logic             if_read_start;
	bank_sel_t        wr_bank;
	bank_sel_t        rd_bank;
	logic             fsld_end, left_done, base_done, right_done;
	logic             block_done;
	logic             started;	// mast_state has left idle once

	int mismatch_cnt = 0;
	int timeout_cnt  = 0;
	// per-mode event counts, cleared while mast_state is idle
	int blk_ker_dn, blk_bias_dn, blk_pad, blk_wr, blk_rd, blk_done, blk_fsld_end;
	int n_fsld_end = 0, n_left = 0, n_base = 0, n_right = 0;
	logic pad_d, wr_d, rd_d;	// previous start levels, edge counting

	always #4 clk = ~clk;	// 8 ns period

	if_sched_top #(.ROW_W(ROW_W)) i_dut (
		.clk, .reset, .mast_state, .cfg_total_row,
		.ker_status, .bias_status, .pad_status, .wr_status, .rd_status,
		.load_starts, .if_write_start, .if_read_start, .wr_bank, .rd_bank,
		.fsld_end, .left_done, .base_done, .right_done
	);

	tb_unit_model i_ker_unit  (.clk, .reset, .start(load_starts.ker),  .status(ker_status));
	tb_unit_model i_bias_unit (.clk, .reset, .start(load_starts.bias), .status(bias_status));
	tb_unit_model i_pad_unit  (.clk, .reset, .start(load_starts.pad),  .status(pad_status));
	tb_unit_model i_wr_unit   (.clk, .reset, .start(if_write_start),   .status(wr_status));
	tb_unit_model i_rd_unit   (.clk, .reset, .start(if_read_start),    .status(rd_status));

	assign block_done = left_done | base_done | right_done;

	task automatic report_mismatch(input string msg);
		mismatch_cnt++;
		$display("mismatch at %0t: %s", $time, msg);
	endtask

	// ----------------------------------------------------------------------
	// event bookkeeping
	// ----------------------------------------------------------------------
	always @(posedge clk) begin
		pad_d <= load_starts.pad;
		wr_d  <= if_write_start;
		rd_d  <= if_read_start;
		if (reset || mast_state == MAST_IDLE) begin
			blk_ker_dn   <= 0;
			blk_bias_dn  <= 0;
			blk_pad      <= 0;
			blk_wr       <= 0;
			blk_rd       <= 0;
			blk_done     <= 0;
			blk_fsld_end <= 0;
		end else begin
			if (ker_status.done)           blk_ker_dn   <= blk_ker_dn + 1;
			if (bias_status.done)          blk_bias_dn  <= blk_bias_dn + 1;
			if (load_starts.pad && !pad_d) blk_pad      <= blk_pad + 1;	// rising edges
			if (if_write_start && !wr_d)   blk_wr       <= blk_wr + 1;
			if (if_read_start && !rd_d)    blk_rd       <= blk_rd + 1;
			if (block_done)                blk_done     <= blk_done + 1;
			if (fsld_end)                  blk_fsld_end <= blk_fsld_end + 1;
		end
		if (fsld_end)   n_fsld_end <= n_fsld_end + 1;
		if (left_done)  n_left     <= n_left + 1;
		if (base_done)  n_base     <= n_base + 1;
		if (right_done) n_right    <= n_right + 1;
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	a_quiet: assert property (@(posedge clk) disable iff (reset)
		!started |-> (load_starts == '0 && !if_write_start && !if_read_start &&
			wr_bank == '0 && rd_bank == '0 && !fsld_end && !block_done))
		else report_mismatch("output active before first mode");
	a_bias_after_ker: assert property (@(posedge clk) disable iff (reset)
		$rose(load_starts.bias) |-> (blk_ker_dn == 1))
		else report_mismatch("bias start before kernel done");
	a_pad_after_bias: assert property (@(posedge clk) disable iff (reset)
		($rose(load_starts.pad) && mast_state == MAST_FSLD) |-> (blk_bias_dn == 1))
		else report_mismatch("pad start before bias done");
	a_fsld_end_pulse: assert property (@(posedge clk) disable iff (reset)
		fsld_end |-> ($past(pad_status.done) && blk_fsld_end == 0) ##1 !fsld_end)
		else report_mismatch("fsld_end not a single pulse after pad done");
	a_one_pad: assert property (@(posedge clk) disable iff (reset)
		$rose(load_starts.pad) |-> (blk_pad == 0 && mast_state != MAST_BASE))
		else report_mismatch("extra pad start");
	a_pad_first: assert property (@(posedge clk) disable iff (reset)
		($rose(if_write_start) && (mast_state == MAST_LEFT || mast_state == MAST_RIGHT))
		|-> (blk_pad == 1))
		else report_mismatch("feature write before padding");
	a_wr_bank_alt: assert property (@(posedge clk) disable iff (reset)
		$rose(if_write_start) |=> (wr_bank.bank0 == !$past(blk_wr[0]) &&
			wr_bank.bank1 == $past(blk_wr[0])))
		else report_mismatch("write bank out of ping-pong order");
	a_wr_bank_excl: assert property (@(posedge clk) disable iff (reset)
		!(wr_bank.bank0 && wr_bank.bank1))
		else report_mismatch("both write banks selected");
	a_rd_bank: assert property (@(posedge clk) disable iff (reset)
		rd_status.busy ? $onehot(rd_bank) : (rd_bank == '0))
		else report_mismatch("read bank not one-hot while busy or not zero while idle");
	a_block_counts: assert property (@(posedge clk) disable iff (reset)
		block_done |-> (blk_wr == cfg_total_row / 3 && blk_rd == cfg_total_row &&
			blk_done == 0))
		else report_mismatch($sformatf("block end with %0d writes, %0d reads, total %0d",
			blk_wr, blk_rd, cfg_total_row));

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	task automatic end_run();
		$display("checks done: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
		if (mismatch_cnt == 0 && timeout_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	task automatic wait_mode_end(input mast_state_e mode);
		int   cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
			case (mode)
				MAST_FSLD: seen = fsld_end;
				MAST_LEFT: seen = left_done;
				MAST_BASE: seen = base_done;
				default:   seen = right_done;
			endcase
		end
		if (!seen) begin
			timeout_cnt++;
			$display("timeout: mode %s gave no end pulse in %0d cycles", mode.name(), cycles);
			end_run();
		end
	endtask

	task automatic run_mode(input mast_state_e mode, input int rows);
		cfg_total_row = ROW_W'(rows);
		mast_state    = mode;
		started       = 1'b1;
		wait_mode_end(mode);
		@(negedge clk);	// mode held over the end pulse's sampling edge
		mast_state = MAST_IDLE;
		repeat (4) @(negedge clk);
	endtask

	initial begin
		reset         = 1'b1;
		mast_state    = MAST_IDLE;
		cfg_total_row = '0;
		started       = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);	// outputs must stay quiet here
		run_mode(MAST_FSLD, 12);
		run_mode(MAST_LEFT, 12);
		run_mode(MAST_BASE, 9);
		run_mode(MAST_RIGHT, 6);
		// exactly one end pulse per mode, none on the other outputs
		assert (n_fsld_end == 1 && n_left == 1 && n_base == 1 && n_right == 1)
			else report_mismatch($sformatf("end pulses fsld %0d left %0d base %0d right %0d",
				n_fsld_end, n_left, n_base, n_right));
		end_run();
	end

endmodule

`default_nettype wire

/* if_sched.f */
sched_state_pkg.sv
sched_bus_pkg.sv
sched_ctrl.sv
load_start_gen.sv
if_write_sched.sv
if_read_sched.sv
if_sched_top.sv
tb_unit_model.sv
tb_if_sched.sv

/* Bender.yml */
package:
  name: if_sched

sources:
  - sched_state_pkg.sv
  - sched_bus_pkg.sv
  - sched_ctrl.sv
  - load_start_gen.sv
  - if_write_sched.sv
  - if_read_sched.sv
  - if_sched_top.sv
  - target: test
    files:
      - tb_unit_model.sv
      - tb_if_sched.sv
